//--- build.f
fb_pkg.sv
fb_bram.sv
display_timings.sv
box_draw.sv
framebuffer.sv
pixel_top.sv
pixel_top_checker.sv
pixel_top_tb.sv

//--- Bender.yml
package:
  name: pixel_fb

sources:
  - fb_pkg.sv
  - fb_bram.sv
  - display_timings.sv
  - box_draw.sv
  - framebuffer.sv
  - pixel_top.sv
  - target: test
    files:
      - pixel_top_checker.sv
      - pixel_top_tb.sv

//--- pixel_top_tb.sv
/*
 * testbench for pixel_top: idle outputs in reset, dvi_de geometry,
 * border box image over two frames and a redraw after a second reset
 */
`timescale 1ns/1ps

module pixel_top_tb;

    typedef struct packed {
        fb_pkg::coord_t x;
        fb_pkg::coord_t y;
        logic           border;
    } probe_t;

    // screen pixels picked out of a captured frame
    localparam int n_probes = 16;
    localparam probe_t probes [n_probes] = '{
        '{0, 0, 1'b1}, '{63, 0, 1'b1}, '{0, 47, 1'b1}, '{63, 47, 1'b1},  // corners
        '{3, 20, 1'b1}, '{60, 20, 1'b1}, '{30, 3, 1'b1}, '{30, 44, 1'b1},
        '{2, 2, 1'b1}, '{33, 46, 1'b1},
        '{4, 20, 1'b0}, '{59, 20, 1'b0}, '{30, 4, 1'b0}, '{30, 43, 1'b0},  // one block in
        '{4, 4, 1'b0}, '{32, 24, 1'b0}
    };

    logic                     clk_pix;
    logic                     rst_n;
    fb_pkg::cidx_t            box_cidx;
    logic                     dvi_hsync;
    logic                     dvi_vsync;
    logic                     dvi_de;
    logic [fb_pkg::chanw-1:0] dvi_r;
    logic [fb_pkg::chanw-1:0] dvi_g;
    logic [fb_pkg::chanw-1:0] dvi_b;

    int            seed;
    fb_pkg::cidx_t cidx_a;  // colour of the first box
    fb_pkg::cidx_t cidx_b;  // colour after the second reset

    // screen tracking, updated on the falling edge
    int             vs_count;
    int             scr_x;
    int             scr_y;
    logic           vsync_q;
    logic           de_q;
    fb_pkg::coord_t runs [$];
    fb_pkg::rgb_t   img [2][fb_pkg::v_active][fb_pkg::h_active];  // frames two and three

    int errors;
    int checks;
    int tests;
    int bad_tests;
    int err_mark;
    int total;
    bit timed_out;

    pixel_top DUT (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .box_cidx  (box_cidx),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;
    end

    always @(negedge clk_pix) begin
        if (!rst_n) begin
            vs_count = 0;
            scr_x    = 0;
            scr_y    = 0;
            vsync_q  = 1'b1;
            de_q     = 1'b0;
            runs.delete();
        end else begin
            if (vsync_q && !dvi_vsync) begin  // new frame follows
                vs_count++;
                scr_x = 0;
                scr_y = 0;
            end
            if (dvi_de) begin
                if (vs_count >= 1 && vs_count <= 2
                        && scr_x < fb_pkg::h_active && scr_y < fb_pkg::v_active) begin
                    img[vs_count-1][scr_y][scr_x] = {dvi_r, dvi_g, dvi_b};
                end
                scr_x++;
            end else if (de_q) begin
                if (vs_count == 1) runs.push_back(fb_pkg::coord_t'(scr_x));
                scr_x = 0;
                scr_y++;
            end
            vsync_q = dvi_vsync;
            de_q    = dvi_de;
        end
    end

    // image rule: border blocks show the box colour, the rest background
    function automatic fb_pkg::rgb_t expected_rgb(input int x, input int y,
                                                  input fb_pkg::cidx_t cidx);
        int   fx;
        int   fy;
        logic on_border;
        fx = x / fb_pkg::fb_scale;
        fy = y / fb_pkg::fb_scale;
        on_border = (fx == 0) || (fx == fb_pkg::fb_width - 1)
                    || (fy == 0) || (fy == fb_pkg::fb_height - 1);
        return on_border ? fb_pkg::palette[cidx] : fb_pkg::palette[0];
    endfunction

    task automatic check_rgb(input string name, input fb_pkg::rgb_t got,
                             input fb_pkg::rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input fb_pkg::coord_t got,
                               input fb_pkg::coord_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t ns %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors != err_mark) bad_tests++;
        $display("[%0t ns] test %0d %s: %s", $time, tests, name,
                 (errors == err_mark) ? "ok" : "errors");
        err_mark = errors;
    endtask

    task automatic wait_frames(input int n, input string what);
        int cycles;
        cycles = 0;
        while (vs_count < n && cycles < n * fb_pkg::h_total * fb_pkg::v_total + 2000) begin
            @(posedge clk_pix);
            cycles++;
        end
        if (vs_count < n) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles waiting for %s", cycles, what);
        end
    endtask

    task automatic wait_line(input int y);
        int cycles;
        cycles = 0;
        while (scr_y < y && cycles < fb_pkg::h_total * fb_pkg::v_total) begin
            @(posedge clk_pix);
            cycles++;
        end
        if (scr_y < y) begin
            timed_out = 1'b1;
            $display("timeout after %0d cycles waiting for screen line %0d", cycles, y);
        end
    endtask

    task automatic apply_reset(input fb_pkg::cidx_t cidx);
        @(negedge clk_pix);
        rst_n    <= 1'b0;
        box_cidx <= cidx;
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n <= 1'b1;
    endtask

    task automatic check_table(input int slot, input fb_pkg::cidx_t cidx, input logic border);
        fb_pkg::rgb_t exp;
        for (int i = 0; i < n_probes; i++) begin
            if (probes[i].border == border) begin
                exp = border ? fb_pkg::palette[cidx] : fb_pkg::palette[0];
                check_rgb($sformatf("dvi_rgb(%0d,%0d)", probes[i].x, probes[i].y),
                          img[slot][probes[i].y][probes[i].x], exp);
            end
        end
    endtask

    task automatic check_image(input int slot, input fb_pkg::cidx_t cidx);
        for (int y = 0; y < fb_pkg::v_active; y++) begin
            for (int x = 0; x < fb_pkg::h_active; x++) begin
                check_rgb($sformatf("dvi_rgb(%0d,%0d)", x, y), img[slot][y][x],
                          expected_rgb(x, y, cidx));
            end
        end
    endtask

    task automatic run_tests();
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        check_bit("dvi_hsync", dvi_hsync, 1'b1);
        check_bit("dvi_vsync", dvi_vsync, 1'b1);
        check_bit("dvi_de", dvi_de, 1'b0);
        check_rgb("dvi_rgb", {dvi_r, dvi_g, dvi_b}, '0);
        rst_n <= 1'b1;
        end_test("outputs idle in reset");

        wait_frames(2, "end of frame two");
        if (timed_out) return;
        check_count("dvi_de runs", fb_pkg::coord_t'(runs.size()),
                    fb_pkg::coord_t'(fb_pkg::v_active));
        foreach (runs[i]) begin
            check_count($sformatf("dvi_de run %0d length", i), runs[i],
                        fb_pkg::coord_t'(fb_pkg::h_active));
        end
        end_test("frame geometry");

        check_table(0, cidx_a, 1'b1);
        end_test("border pixels");
        check_table(0, cidx_a, 1'b0);
        end_test("interior pixels");

        @(negedge clk_pix);
        box_cidx <= cidx_b;  // only a second drawing pass could pick this up
        wait_frames(3, "end of frame three");
        if (timed_out) return;
        check_image(1, cidx_a);
        end_test("frame three image");

        wait_line(20);  // reset lands mid frame
        if (timed_out) return;
        apply_reset(cidx_b);
        wait_frames(2, "end of frame two after reset");
        if (timed_out) return;
        check_table(0, cidx_b, 1'b1);
        check_table(0, cidx_b, 1'b0);
        check_image(0, cidx_b);
        end_test("redraw after reset");
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        tests     = 0;
        bad_tests = 0;
        err_mark  = 0;
        timed_out = 1'b0;
        seed      = 32'h8d642ea5;
        cidx_a    = fb_pkg::cidx_t'($random(seed));
        if (cidx_a == '0) cidx_a = 1;
        cidx_b    = fb_pkg::cidx_t'($random(seed));
        if (cidx_b == '0 || cidx_b == cidx_a) begin
            cidx_b = (cidx_a == 15) ? 1 : cidx_a + 1;
        end
        rst_n     = 1'b0;
        box_cidx  = cidx_a;

        run_tests();

        if (timed_out) $display("run stopped early by a timeout");
        total = errors + DUT.checker_inst.assert_fails;
        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors, %0d assertion hits",
                 tests, bad_tests, checks, errors, DUT.checker_inst.assert_fails);
        if (!timed_out && total == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- pixel_top_checker.sv
/*
 * concurrent assertions on the pixel_top output pins,
 * bound into pixel_top
 */
`timescale 1ns/1ps

module pixel_top_checker (
    input logic                     clk_pix,
    input logic                     rst_n,
    input logic                     dvi_hsync,
    input logic                     dvi_vsync,
    input logic                     dvi_de,
    input logic [fb_pkg::chanw-1:0] dvi_r,
    input logic [fb_pkg::chanw-1:0] dvi_g,
    input logic [fb_pkg::chanw-1:0] dvi_b
);

    int assert_fails = 0;  // failure count

    de_in_sync: assert property (@(posedge clk_pix) disable iff (!rst_n)
        dvi_de |-> (dvi_hsync && dvi_vsync))
    else begin
        assert_fails++;
        $error("dvi_de high during a sync pulse");
    end

    // black outside the active area
    blank_black: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !dvi_de |-> ({dvi_r, dvi_g, dvi_b} == '0))
    else begin
        assert_fails++;
        $error("rgb not zero while dvi_de is low");
    end

    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(dvi_hsync) |-> !dvi_hsync [*fb_pkg::h_sync] ##1 dvi_hsync)
    else begin
        assert_fails++;
        $error("dvi_hsync pulse width wrong");
    end

endmodule

bind pixel_top pixel_top_checker checker_inst (
    .clk_pix   (clk_pix),
    .rst_n     (rst_n),
    .dvi_hsync (dvi_hsync),
    .dvi_vsync (dvi_vsync),
    .dvi_de    (dvi_de),
    .dvi_r     (dvi_r),
    .dvi_g     (dvi_g),
    .dvi_b     (dvi_b)
);

//--- pixel_top.sv
/*
 * top level: display timing, box drawing engine and
 * framebuffer, output pixel broken out onto the pins
 */
`timescale 1ns/1ps

module pixel_top (
    input  logic                     clk_pix,
    input  logic                     rst_n,
    input  fb_pkg::cidx_t            box_cidx,
    output logic                     dvi_hsync,
    output logic                     dvi_vsync,
    output logic                     dvi_de,
    output logic [fb_pkg::chanw-1:0] dvi_r,
    output logic [fb_pkg::chanw-1:0] dvi_g,
    output logic [fb_pkg::chanw-1:0] dvi_b
);

    fb_pkg::timing_t timing;
    fb_pkg::fb_wr_t  fb_wr;
    fb_pkg::dvi_t    pixel;
    logic            frame;

    display_timings timing_inst (
        .clk_pix,
        .rst_n,
        .timing,
        .frame,
        .line    ()  // nothing here works per line
    );

    box_draw draw_inst (
        .clk_pix,
        .rst_n,
        .frame,
        .box_cidx,
        .wr       (fb_wr)
    );

    framebuffer fb_inst (
        .clk_pix,
        .rst_n,
        .timing,
        .wr      (fb_wr),
        .pixel
    );

    assign dvi_hsync = pixel.hsync;
    assign dvi_vsync = pixel.vsync;
    assign dvi_de    = pixel.de;
    assign dvi_r     = pixel.rgb.r;
    assign dvi_g     = pixel.rgb.g;
    assign dvi_b     = pixel.rgb.b;

endmodule

//--- framebuffer.sv
/*
 * framebuffer: colour index store, scaled read addressing,
 * palette lookup and sync delay to match the two RAM stages
 */
`timescale 1ns/1ps

module framebuffer (
    input  logic            clk_pix,
    input  logic            rst_n,
    input  fb_pkg::timing_t timing,
    input  fb_pkg::fb_wr_t  wr,
    output fb_pkg::dvi_t    pixel
);

    // write side
    fb_pkg::coord_t wr_lin;
    logic           wr_ok;

    always_comb begin
        wr_lin = fb_pkg::coord_t'(wr.y * fb_pkg::fb_width + wr.x);
        // drop anything off the edge of the framebuffer
        wr_ok  = wr.we
                 && (wr.x >= 0) && (wr.x < fb_pkg::fb_width)
                 && (wr.y >= 0) && (wr.y < fb_pkg::fb_height);
    end

    // read side, each screen pixel maps to fb (sx/scale, sy/scale)
    fb_pkg::coord_t rd_lin;
    logic [fb_pkg::fb_addrw-1:0] rd_addr;

    always_comb begin
        rd_lin = fb_pkg::coord_t'((timing.sy / fb_pkg::fb_scale) * fb_pkg::fb_width
                                  + timing.sx / fb_pkg::fb_scale);
        // park the address in blanking so it stays inside the RAM
        rd_addr = timing.de ? rd_lin[fb_pkg::fb_addrw-1:0] : '0;
    end

    fb_pkg::cidx_t cidx_rd;  // valid one cycle after timing
    fb_pkg::rgb_t  rgb_rd;   // valid two cycles after timing

    fb_bram #(
        .payload_t (fb_pkg::cidx_t),
        .depth     (fb_pkg::fb_depth)
    ) image_ram (
        .clk_pix,
        .we         (wr_ok),
        .addr_write (wr_lin[fb_pkg::fb_addrw-1:0]),
        .data_in    (wr.cidx),
        .addr_read  (rd_addr),
        .data_out   (cidx_rd)
    );

    // palette held as a ROM, write port tied off
    fb_bram #(
        .payload_t (fb_pkg::rgb_t),
        .depth     (fb_pkg::pal_depth),
        .init      (fb_pkg::palette)
    ) palette_rom (
        .clk_pix,
        .we         (1'b0),
        .addr_write ('0),
        .data_in    ('0),
        .addr_read  (cidx_rd),
        .data_out   (rgb_rd)
    );

    // two-stage delay on the control signals
    logic [1:0] hsync_sr;
    logic [1:0] vsync_sr;
    logic [1:0] de_sr;

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            hsync_sr <= 2'b11;
            vsync_sr <= 2'b11;
            de_sr    <= 2'b00;
        end else begin
            hsync_sr <= {hsync_sr[0], timing.hsync};
            vsync_sr <= {vsync_sr[0], timing.vsync};
            de_sr    <= {de_sr[0], timing.de};
        end
    end

    always_comb begin
        pixel.hsync = hsync_sr[1];
        pixel.vsync = vsync_sr[1];
        pixel.de    = de_sr[1];
        pixel.rgb   = de_sr[1] ? rgb_rd : '0;  // black in blanking
    end

endmodule

//--- box_draw.sv
/*
 * drawing engine: writes a one-pixel border box into the
 * framebuffer once, starting on the first frame pulse
 */
`timescale 1ns/1ps

module box_draw (
    input  logic           clk_pix,
    input  logic           rst_n,
    input  logic           frame,
    input  fb_pkg::cidx_t  box_cidx,
    output fb_pkg::fb_wr_t wr
);

    typedef enum logic [2:0] {
        s_idle,
        s_top,
        s_right,
        s_left,
        s_bottom,
        s_done
    } state_t;

    state_t         state;
    logic           we_q;
    fb_pkg::coord_t x_q;
    fb_pkg::coord_t y_q;
    fb_pkg::cidx_t  cidx_q;

    // one write per cycle while we_q is high
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state  <= s_idle;
            we_q   <= 1'b0;
            x_q    <= '0;
            y_q    <= '0;
            cidx_q <= '0;
        end else begin
            case (state)
                s_idle: if (frame) begin
                    x_q    <= '0;
                    y_q    <= '0;
                    cidx_q <= box_cidx;  // colour fixed for the whole box
                    we_q   <= 1'b1;
                    state  <= s_top;
                end
                s_top: if (x_q < fb_pkg::fb_width - 1) begin
                    x_q <= fb_pkg::coord_t'(x_q + 1);
                end else begin
                    state <= s_right;  // x stays on the last column
                end
                s_right: if (y_q < fb_pkg::fb_height - 1) begin
                    y_q <= fb_pkg::coord_t'(y_q + 1);
                end else begin
                    x_q   <= '0;
                    y_q   <= '0;
                    state <= s_left;
                end
                s_left: if (y_q < fb_pkg::fb_height - 1) begin
                    y_q <= fb_pkg::coord_t'(y_q + 1);
                end else begin
                    state <= s_bottom;  // bottom row from (0, last)
                end
                s_bottom: if (x_q < fb_pkg::fb_width - 1) begin
                    x_q <= fb_pkg::coord_t'(x_q + 1);
                end else begin
                    we_q  <= 1'b0;
                    state <= s_done;
                end
                s_done: state <= s_done;  // held until reset
                default: state <= s_done;
            endcase
        end
    end

    assign wr = '{we: we_q, x: x_q, y: y_q, cidx: cidx_q};

endmodule

//--- display_timings.sv
/*
 * display timing generator: pixel and line counters with
 * registered sync, data enable, position and frame/line pulses
 */
`timescale 1ns/1ps

module display_timings (
    input  logic            clk_pix,
    input  logic            rst_n,
    output fb_pkg::timing_t timing,
    output logic            frame,
    output logic            line
);

    fb_pkg::coord_t x;  // raw counters, one cycle ahead of timing
    fb_pkg::coord_t y;

    logic x_last;
    logic y_last;

    assign x_last = (x == fb_pkg::h_total - 1);
    assign y_last = (y == fb_pkg::v_total - 1);

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (x_last) begin
            x <= '0;
            if (y_last) begin
                y <= '0;
            end else begin
                y <= fb_pkg::coord_t'(y + 1);
            end
        end else begin
            x <= fb_pkg::coord_t'(x + 1);
        end
    end

    // decode from the counters and register everything
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            timing.sx    <= '0;
            timing.sy    <= '0;
            timing.hsync <= 1'b1;  // idle high
            timing.vsync <= 1'b1;
            timing.de    <= 1'b0;
            frame        <= 1'b0;
            line         <= 1'b0;
        end else begin
            timing.sx    <= x;
            timing.sy    <= y;
            timing.hsync <= !(x >= fb_pkg::h_sync_start && x < fb_pkg::h_sync_end);
            timing.vsync <= !(y >= fb_pkg::v_sync_start && y < fb_pkg::v_sync_end);
            timing.de    <= (x < fb_pkg::h_active) && (y < fb_pkg::v_active);
            frame        <= (x == 0) && (y == 0);
            line         <= (x == 0);
        end
    end

endmodule

//--- fb_bram.sv
/*
 * simple dual-port block RAM, registered read,
 * payload type and optional initial contents as parameters
 */
`timescale 1ns/1ps

module fb_bram #(
    parameter type      payload_t   = logic [7:0],
    parameter int       depth       = 16,
    parameter payload_t init [depth] = '{default: '0}  // palette ROM contents
) (
    input  logic                     clk_pix,
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] addr_write,
    input  payload_t                 data_in,
    input  logic [$clog2(depth)-1:0] addr_read,
    output payload_t                 data_out
);

    payload_t mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = init[i];
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
        data_out <= mem[addr_read];  // one cycle read
    end

endmodule

//--- fb_pkg.sv
/*
 * shared localparams, types and colour palette for the
 * framebuffer display pipeline (reduced 64x48 test mode)
 */
package fb_pkg;

    // display timing, horizontal in pixels
    localparam int h_active = 64;
    localparam int h_front  = 4;
    localparam int h_sync   = 8;
    localparam int h_back   = 4;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 80

    // display timing, vertical in lines
    localparam int v_active = 48;
    localparam int v_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 2;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 54

    // sync pulse windows
    localparam int h_sync_start = h_active + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync;
    localparam int v_sync_start = v_active + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    localparam int cordw = 16;  // screen and fb coordinate width

    // framebuffer geometry
    localparam int fb_width  = 16;
    localparam int fb_height = 12;
    localparam int fb_scale  = 4;
    localparam int fb_depth  = fb_width * fb_height;
    localparam int fb_addrw  = $clog2(fb_depth);

    localparam int cidxw     = 4;  // colour index bits
    localparam int chanw     = 4;  // bits per colour channel
    localparam int pal_depth = 1 << cidxw;

    typedef logic signed [cordw-1:0] coord_t;
    typedef logic [cidxw-1:0] cidx_t;

    typedef struct packed {
        logic [chanw-1:0] r;
        logic [chanw-1:0] g;
        logic [chanw-1:0] b;
    } rgb_t;

    // raw timing for one pixel, syncs active low
    typedef struct packed {
        coord_t sx;
        coord_t sy;
        logic   hsync;
        logic   vsync;
        logic   de;
    } timing_t;

    typedef struct packed {
        logic   we;
        coord_t x;
        coord_t y;
        cidx_t  cidx;
    } fb_wr_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } dvi_t;

    // entry 0 is the background, the rest all differ from it
    localparam rgb_t palette [pal_depth] = '{
        12'h137, 12'hfff, 12'hf00, 12'h0f0,
        12'h00f, 12'hff0, 12'h0ff, 12'hf0f,
        12'hf80, 12'h8f0, 12'h08f, 12'hf08,
        12'h888, 12'h444, 12'hccc, 12'h000
    };

endpackage
